// File: div_pkg.sv
`default_nettype none

package div_pkg;

    // operand and result width
    localparam int XLEN = 32;

    // one restoring cell per quotient bit
    localparam int DIV_STAGES = XLEN;

    // prep register + one per cell + result register
    localparam int DIV_LATENCY = DIV_STAGES + 2;

    // low two bits of funct3
    // bit 0 set is unsigned, bit 1 set selects the remainder
    typedef logic [1:0] div_op_t;

    localparam div_op_t OP_DIV  = 2'd0;
    localparam div_op_t OP_DIVU = 2'd1;
    localparam div_op_t OP_REM  = 2'd2;
    localparam div_op_t OP_REMU = 2'd3;

endpackage

`default_nettype wire

// File: div_operand_prep.sv
`timescale 1ns/1ns
`default_nettype none

module div_operand_prep (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        in_valid,
    input  wire div_pkg::div_op_t      op,
    input  wire [div_pkg::XLEN-1:0]    dividend,
    input  wire [div_pkg::XLEN-1:0]    divisor,
    output logic                       valid_out,
    output logic [div_pkg::XLEN-1:0]   rem_out,
    output logic [div_pkg::XLEN-1:0]   dvd_out,
    output logic [div_pkg::XLEN-1:0]   dvs_out,
    output logic [div_pkg::XLEN-1:0]   quot_out,
    output logic                       neg_quot_out,
    output logic                       neg_rem_out,
    output logic                       sel_rem_out
);
    import div_pkg::*;

    logic            is_signed;
    logic            dvd_neg;
    logic            dvs_neg;
    logic            dvs_zero;
    logic [XLEN-1:0] dvd_mag;
    logic [XLEN-1:0] dvs_mag;

    assign is_signed = ~op[0];
    assign dvd_neg   = is_signed & dividend[XLEN-1];
    assign dvs_neg   = is_signed & divisor[XLEN-1];
    assign dvs_zero  = ~|divisor;

    // most negative value maps to itself, still correct as unsigned magnitude
    assign dvd_mag = dvd_neg ? (~dividend + 1'b1) : dividend;
    assign dvs_mag = dvs_neg ? (~divisor + 1'b1) : divisor;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_out    <= 1'b0;
            rem_out      <= '0;
            dvd_out      <= '0;
            dvs_out      <= '0;
            quot_out     <= '0;
            neg_quot_out <= 1'b0;
            neg_rem_out  <= 1'b0;
            sel_rem_out  <= 1'b0;
        end else begin
            valid_out    <= in_valid;
            rem_out      <= '0;                 // partial remainder starts empty
            dvd_out      <= dvd_mag;
            dvs_out      <= dvs_mag;
            quot_out     <= '0;
            // divide by zero keeps the all-ones quotient
            neg_quot_out <= (dvd_neg ^ dvs_neg) & ~dvs_zero;
            neg_rem_out  <= dvd_neg;            // remainder follows dividend sign
            sel_rem_out  <= op[1];
        end
    end

endmodule

`default_nettype wire

// File: div_cell.sv
`timescale 1ns/1ns
`default_nettype none

module div_cell (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        valid_in,
    input  wire [div_pkg::XLEN-1:0]    rem_in,
    input  wire [div_pkg::XLEN-1:0]    dvd_in,
    input  wire [div_pkg::XLEN-1:0]    dvs_in,
    input  wire [div_pkg::XLEN-1:0]    quot_in,
    input  wire                        neg_quot_in,
    input  wire                        neg_rem_in,
    input  wire                        sel_rem_in,
    output logic                       valid_out,
    output logic [div_pkg::XLEN-1:0]   rem_out,
    output logic [div_pkg::XLEN-1:0]   dvd_out,
    output logic [div_pkg::XLEN-1:0]   dvs_out,
    output logic [div_pkg::XLEN-1:0]   quot_out,
    output logic                       neg_quot_out,
    output logic                       neg_rem_out,
    output logic                       sel_rem_out
);
    import div_pkg::*;

    logic [XLEN:0]   shifted;
    logic [XLEN:0]   diff;
    logic            q_bit;
    logic [XLEN-1:0] rem_next;

    // bring down the next dividend bit
    assign shifted = {rem_in, dvd_in[XLEN-1]};

    // trial subtract, sign bit tells whether the divisor fit
    assign diff  = shifted - {1'b0, dvs_in};
    assign q_bit = ~diff[XLEN];

    // on restore the shifted value is below the divisor so it fits in XLEN bits
    assign rem_next = q_bit ? diff[XLEN-1:0] : shifted[XLEN-1:0];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_out    <= 1'b0;
            rem_out      <= '0;
            dvd_out      <= '0;
            dvs_out      <= '0;
            quot_out     <= '0;
            neg_quot_out <= 1'b0;
            neg_rem_out  <= 1'b0;
            sel_rem_out  <= 1'b0;
        end else begin
            valid_out    <= valid_in;
            rem_out      <= rem_next;
            dvd_out      <= {dvd_in[XLEN-2:0], 1'b0};
            dvs_out      <= dvs_in;
            quot_out     <= {quot_in[XLEN-2:0], q_bit};   // msb first
            neg_quot_out <= neg_quot_in;
            neg_rem_out  <= neg_rem_in;
            sel_rem_out  <= sel_rem_in;
        end
    end

endmodule

`default_nettype wire

// File: div_result_fix.sv
`timescale 1ns/1ns
`default_nettype none

module div_result_fix (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        valid_in,
    input  wire [div_pkg::XLEN-1:0]    rem_in,
    input  wire [div_pkg::XLEN-1:0]    quot_in,
    input  wire                        neg_quot_in,
    input  wire                        neg_rem_in,
    input  wire                        sel_rem_in,
    output logic                       out_valid,
    output logic [div_pkg::XLEN-1:0]   result
);
    import div_pkg::*;

    logic [XLEN-1:0] quot_fix;
    logic [XLEN-1:0] rem_fix;
    logic [XLEN-1:0] result_next;

    // signs decided in the prep stage and carried down the chain
    assign quot_fix = neg_quot_in ? (~quot_in + 1'b1) : quot_in;
    assign rem_fix  = neg_rem_in ? (~rem_in + 1'b1) : rem_in;

    assign result_next = sel_rem_in ? rem_fix : quot_fix;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= valid_in;
            result    <= result_next;
        end
    end

endmodule

`default_nettype wire

// File: div_unit.sv
`timescale 1ns/1ns
`default_nettype none

module div_unit (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        in_valid,
    input  wire div_pkg::div_op_t      op,
    input  wire [div_pkg::XLEN-1:0]    dividend,
    input  wire [div_pkg::XLEN-1:0]    divisor,
    output logic                       out_valid,
    output logic [div_pkg::XLEN-1:0]   result
);
    import div_pkg::*;

    // index 0 is the prep output, index DIV_STAGES feeds the result stage
    wire            valid_s    [0:DIV_STAGES];
    wire [XLEN-1:0] rem_s      [0:DIV_STAGES];
    wire [XLEN-1:0] dvd_s      [0:DIV_STAGES];
    wire [XLEN-1:0] dvs_s      [0:DIV_STAGES];
    wire [XLEN-1:0] quot_s     [0:DIV_STAGES];
    wire            neg_quot_s [0:DIV_STAGES];
    wire            neg_rem_s  [0:DIV_STAGES];
    wire            sel_rem_s  [0:DIV_STAGES];

    div_operand_prep prep_inst (
        .clk          (clk),
        .rstn         (rstn),
        .in_valid     (in_valid),
        .op           (op),
        .dividend     (dividend),
        .divisor      (divisor),
        .valid_out    (valid_s[0]),
        .rem_out      (rem_s[0]),
        .dvd_out      (dvd_s[0]),
        .dvs_out      (dvs_s[0]),
        .quot_out     (quot_s[0]),
        .neg_quot_out (neg_quot_s[0]),
        .neg_rem_out  (neg_rem_s[0]),
        .sel_rem_out  (sel_rem_s[0])
    );

    for (genvar i = 0; i < DIV_STAGES; i++) begin : g_cell
        div_cell cell_inst (
            .clk          (clk),
            .rstn         (rstn),
            .valid_in     (valid_s[i]),
            .rem_in       (rem_s[i]),
            .dvd_in       (dvd_s[i]),
            .dvs_in       (dvs_s[i]),
            .quot_in      (quot_s[i]),
            .neg_quot_in  (neg_quot_s[i]),
            .neg_rem_in   (neg_rem_s[i]),
            .sel_rem_in   (sel_rem_s[i]),
            .valid_out    (valid_s[i+1]),
            .rem_out      (rem_s[i+1]),
            .dvd_out      (dvd_s[i+1]),
            .dvs_out      (dvs_s[i+1]),
            .quot_out     (quot_s[i+1]),
            .neg_quot_out (neg_quot_s[i+1]),
            .neg_rem_out  (neg_rem_s[i+1]),
            .sel_rem_out  (sel_rem_s[i+1])
        );
    end

    div_result_fix fix_inst (
        .clk         (clk),
        .rstn        (rstn),
        .valid_in    (valid_s[DIV_STAGES]),
        .rem_in      (rem_s[DIV_STAGES]),
        .quot_in     (quot_s[DIV_STAGES]),
        .neg_quot_in (neg_quot_s[DIV_STAGES]),
        .neg_rem_in  (neg_rem_s[DIV_STAGES]),
        .sel_rem_in  (sel_rem_s[DIV_STAGES]),
        .out_valid   (out_valid),
        .result      (result)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    // 20 ns period, first rising edge at 10 ns
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;                // released away from the rising edge
    end

endmodule

`default_nettype wire

// File: tb_div_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_div_unit;
    import div_pkg::*;

    logic            clk;
    logic            rstn;
    logic            in_valid;
    div_op_t         op;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
    logic            out_valid;
    logic [XLEN-1:0] result;

    logic [XLEN-1:0] want_q[$];         // expected results in issue order
    int              issue_q[$];        // cycle each op was driven
    logic [XLEN-1:0] dir_op[$];
    logic [XLEN-1:0] dir_a[$];
    logic [XLEN-1:0] dir_b[$];
    logic [XLEN-1:0] dir_want[$];
    int              dir_gap[$];
    int              cycle_count = 0;
    int              timeout_limit = 100000;
    int              mismatch_count = 0;
    int              other_count = 0;
    logic [31:0]     lfsr_state = 32'h8c04_5f4e;

    tb_clock_gen clk_gen_inst (
        .clk  (clk),
        .rstn (rstn)
    );

    div_unit div_unit_inst (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .op        (op),
        .dividend  (dividend),
        .divisor   (divisor),
        .out_valid (out_valid),
        .result    (result)
    );

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // RISC-V M rules: truncate toward zero, remainder has dividend sign
    function automatic logic [XLEN-1:0] ref_result(input div_op_t o, input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic [XLEN-1:0] q;
        logic [XLEN-1:0] r;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (!o[0]) begin
            if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                q = a;                  // signed overflow
                r = '0;
            end else begin
                q = $signed(a) / $signed(b);
                r = $signed(a) % $signed(b);
            end
        end else begin
            q = a / b;
            r = a % b;
        end
        return o[1] ? r : q;
    endfunction

    task check_value(input string name, input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
        if (got !== want) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task issue_op(input div_op_t o, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                  input logic [XLEN-1:0] want);
        in_valid = 1'b1;
        op       = o;
        dividend = a;
        divisor  = b;
        want_q.push_back(want);
        issue_q.push_back(cycle_count);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task load_stim(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op, f_a, f_b, f_want, f_gap;
        ok = 1'b0;
        fd = $fopen("div_unit_stim.txt", "r");
        if (fd == 0) begin
            other_count++;
            $display("could not open div_unit_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_want, f_gap);
            if (n == 5) begin
                dir_op.push_back(f_op);
                dir_a.push_back(f_a);
                dir_b.push_back(f_b);
                dir_want.push_back(f_want);
                dir_gap.push_back(int'(f_gap));
            end else if (n > 0) begin
                other_count++;
                $display("stim line has too few fields: %s", line);
            end
        end
        $fclose(fd);
        ok = 1'b1;
    endtask

    // outputs sampled on the falling edge, away from register updates
    always @(negedge clk) begin
        if (!rstn) begin
            if (out_valid !== 1'b0) begin
                other_count++;
                $display("out_valid was not low during reset at %0t ns", $time);
            end
        end else if (out_valid === 1'b1) begin
            if (want_q.size() == 0) begin
                other_count++;
                $display("out_valid at %0t ns with no operation in flight", $time);
            end else begin
                check_value("result", result, want_q.pop_front());
                check_value("out_valid latency", cycle_count - issue_q.pop_front(), DIV_LATENCY);
            end
        end else if (out_valid !== 1'b0) begin
            other_count++;
            $display("out_valid is unknown at %0t ns", $time);
        end
    end

    always @(negedge clk) begin
        if (cycle_count >= timeout_limit) begin
            $display("run did not finish within %0d cycles", timeout_limit);
            $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        bit              ok;
        int              total;
        logic [31:0]     r_op, r_a, r_b, mode;
        logic [XLEN-1:0] want;
        in_valid = 1'b0;
        op       = OP_DIV;
        dividend = '0;
        divisor  = '0;
        load_stim(ok);
        if (ok) begin
            total = 0;
            foreach (dir_gap[i])
                total += 1 + dir_gap[i];
            timeout_limit = 16 + total + 200 + DIV_LATENCY + 50;
            wait (rstn === 1'b1);
            @(negedge clk);
            foreach (dir_op[i]) begin
                issue_op(div_op_t'(dir_op[i][1:0]), dir_a[i], dir_b[i], dir_want[i]);
                repeat (dir_gap[i]) @(negedge clk);
            end
            // back to back, mixed opcodes
            repeat (200) begin
                take_bits(2, r_op);
                take_bits(32, r_a);
                take_bits(32, r_b);
                take_bits(2, mode);
                if (mode == 0)
                    r_b = r_b >> 20;    // small divisor, wide quotient
                want = ref_result(div_op_t'(r_op[1:0]), r_a, r_b);
                issue_op(div_op_t'(r_op[1:0]), r_a, r_b, want);
            end
            repeat (DIV_LATENCY + 4) @(negedge clk);
            if (want_q.size() != 0) begin
                other_count++;
                $display("%0d results never came out", want_q.size());
            end
        end
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: div_unit_stim.txt
# columns: op dividend divisor expected idle_cycles, all hex
# op 0 DIV, 1 DIVU, 2 REM, 3 REMU
0 00000014 00000006 00000003 0
0 ffffffec 00000006 fffffffd 0
0 00000014 fffffffa fffffffd 0
0 ffffffec fffffffa 00000003 2
2 00000014 00000006 00000002 0
2 ffffffec 00000006 fffffffe 0
2 00000014 fffffffa 00000002 0
2 ffffffec fffffffa fffffffe 3
1 ffffffec 00000006 2aaaaaa7 0
3 ffffffec 00000006 00000002 0
1 00000014 fffffffa 00000000 0
3 00000014 fffffffa 00000014 1
0 12345678 00000000 ffffffff 0
0 fffffff9 00000000 ffffffff 0
1 12345678 00000000 ffffffff 0
2 fffffff9 00000000 fffffff9 0
3 12345678 00000000 12345678 2
0 80000000 ffffffff 80000000 0
2 80000000 ffffffff 00000000 0
1 80000000 ffffffff 00000000 0
3 80000000 ffffffff 80000000 4
0 7fffffff 00000001 7fffffff 0
0 80000000 00000002 c0000000 0
2 80000000 00000003 fffffffe 0
1 ffffffff ffffffff 00000001 0
0 00000000 00000005 00000000 0
2 ffffffff 00000001 00000000 5

// File: div_unit.f
div_pkg.sv
div_operand_prep.sv
div_cell.sv
div_result_fix.sv
div_unit.sv
tb_clock_gen.sv
tb_div_unit.sv
